// File: Makefile
TOP = cpu_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | \
		grep -x "Finished with no errors" > /dev/null

obj_dir/V$(TOP): build.f src/*.sv test/*.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: build.f
src/cpu_pkg.sv
src/register_file.sv
src/alu.sv
src/instr_mem.sv
src/cpu.sv
src/cpu_subsystem.sv
test/tb_clock_gen.sv
test/cpu_checker.sv
test/cpu_tb.sv

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::alu_op_e           op,
    input  logic [cpu_pkg::xlen-1:0]   a,
    input  logic [cpu_pkg::xlen-1:0]   b,
    output logic [cpu_pkg::xlen-1:0]   result
);
    logic [4:0] shamt;

    assign shamt = b[4:0];  // RV32I shifts use 5 bits

    always_comb begin
        case (op)
            cpu_pkg::alu_add:  result = a + b;
            cpu_pkg::alu_sub:  result = a - b;
            cpu_pkg::alu_sll:  result = a << shamt;
            cpu_pkg::alu_slt: begin
                result = {{(cpu_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            cpu_pkg::alu_sltu: begin
                result = {{(cpu_pkg::xlen-1){1'b0}}, a < b};
            end
            cpu_pkg::alu_xor:  result = a ^ b;
            cpu_pkg::alu_srl:  result = a >> shamt;
            cpu_pkg::alu_sra:  result = $signed(a) >>> shamt;  // Sign fill
            cpu_pkg::alu_or:   result = a | b;
            cpu_pkg::alu_and:  result = a & b;
            default:           result = '0;
        endcase
    end

endmodule

// File: src/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic                       clk,
    input  logic                       reset_n,
    output cpu_pkg::fetch_req_t        fetch_req,
    input  logic [cpu_pkg::xlen-1:0]   fetch_data,
    output cpu_pkg::retire_t           retire
);
    logic [cpu_pkg::xlen-1:0] pc;
    logic                     fetch_valid;
    logic                     ifid_valid;
    logic [cpu_pkg::xlen-1:0] ifid_pc;
    cpu_pkg::idex_t           idex;
    cpu_pkg::idex_t           id_next;
    cpu_pkg::exmem_t          exmem;
    cpu_pkg::memwb_t          memwb;
    logic                     branch_taken;

    // Pick the newest in-flight value of a source register
    function automatic logic [cpu_pkg::xlen-1:0] forward(
        input logic [cpu_pkg::reg_addr_w-1:0] rs,
        input logic [cpu_pkg::xlen-1:0]       rf_value,
        input cpu_pkg::exmem_t                ex,
        input cpu_pkg::memwb_t                wb
    );
        if (ex.valid && ex.reg_write && ex.rd != '0 && ex.rd == rs) return ex.result;
        if (wb.valid && wb.reg_write && wb.rd != '0 && wb.rd == rs) return wb.result;
        return rf_value;
    endfunction

    // ------------------------------------------------------------
    // Fetch
    // ------------------------------------------------------------
    assign branch_taken = exmem.valid && exmem.branch_op == cpu_pkg::beq && exmem.zero;

    assign fetch_req.valid = fetch_valid;
    assign fetch_req.addr  = pc;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
            ifid_valid  <= 1'b0;
            ifid_pc     <= '0;
        end else begin
            fetch_valid <= 1'b1;
            ifid_valid  <= fetch_valid && !branch_taken;  // Youngest of the three flushed
            ifid_pc     <= pc;
            if (branch_taken) begin
                pc <= exmem.target;
            end else if (fetch_valid) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    logic [6:0]                     id_opcode;
    logic [2:0]                     id_funct3;
    logic                           id_funct7_5;    // sub / sra select
    logic [cpu_pkg::reg_addr_w-1:0] id_rs1;
    logic [cpu_pkg::reg_addr_w-1:0] id_rs2;
    logic [cpu_pkg::xlen-1:0]       id_i_imm;
    logic [cpu_pkg::xlen-1:0]       id_b_imm;
    logic [cpu_pkg::xlen-1:0]       rf_data1;
    logic [cpu_pkg::xlen-1:0]       rf_data2;

    assign id_opcode   = fetch_data[6:0];
    assign id_funct3   = fetch_data[14:12];
    assign id_funct7_5 = fetch_data[30];
    assign id_rs1      = fetch_data[19:15];
    assign id_rs2      = fetch_data[24:20];
    assign id_i_imm    = {{20{fetch_data[31]}}, fetch_data[31:20]};
    assign id_b_imm    = {{20{fetch_data[31]}}, fetch_data[7], fetch_data[30:25],
                          fetch_data[11:8], 1'b0};

    register_file u_register_file (
        .clk          (clk),
        .read_reg1    (id_rs1),
        .read_reg2    (id_rs2),
        .write_enable (memwb.valid && memwb.reg_write),
        .write_reg    (memwb.rd),
        .write_data   (memwb.result),
        .read_data1   (rf_data1),
        .read_data2   (rf_data2)
    );

    always_comb begin
        id_next           = '0;
        id_next.alu_op    = cpu_pkg::alu_add;
        id_next.alu_src   = cpu_pkg::alu_src_reg;
        id_next.branch_op = cpu_pkg::not_branch;
        id_next.pc        = ifid_pc;
        id_next.rs1       = id_rs1;
        id_next.rs2       = id_rs2;
        id_next.rd        = fetch_data[11:7];
        id_next.rs1_data  = rf_data1;
        id_next.rs2_data  = rf_data2;
        id_next.imm       = id_i_imm;

        case (id_opcode)
            cpu_pkg::opcode_op: begin
                id_next.valid     = ifid_valid;
                id_next.reg_write = 1'b1;
                case (id_funct3)
                    3'b000: id_next.alu_op = id_funct7_5 ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                    3'b001: id_next.alu_op = cpu_pkg::alu_sll;
                    3'b010: id_next.alu_op = cpu_pkg::alu_slt;
                    3'b011: id_next.alu_op = cpu_pkg::alu_sltu;
                    3'b100: id_next.alu_op = cpu_pkg::alu_xor;
                    3'b101: id_next.alu_op = id_funct7_5 ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
                    3'b110: id_next.alu_op = cpu_pkg::alu_or;
                    default: id_next.alu_op = cpu_pkg::alu_and;
                endcase
            end
            cpu_pkg::opcode_op_imm: begin
                id_next.valid     = ifid_valid;
                id_next.reg_write = 1'b1;
                id_next.alu_src   = cpu_pkg::alu_src_imm;
                case (id_funct3)
                    3'b000: id_next.alu_op = cpu_pkg::alu_add;
                    3'b001: id_next.alu_op = cpu_pkg::alu_sll;  // ALU only sees imm[4:0]
                    3'b010: id_next.alu_op = cpu_pkg::alu_slt;
                    3'b011: id_next.alu_op = cpu_pkg::alu_sltu;
                    3'b100: id_next.alu_op = cpu_pkg::alu_xor;
                    3'b101: id_next.alu_op = id_funct7_5 ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
                    3'b110: id_next.alu_op = cpu_pkg::alu_or;
                    default: id_next.alu_op = cpu_pkg::alu_and;
                endcase
            end
            cpu_pkg::opcode_branch: begin
                // Only BEQ, other branch kinds become bubbles
                id_next.valid     = ifid_valid && id_funct3 == 3'b000;
                id_next.branch_op = cpu_pkg::beq;
                id_next.alu_op    = cpu_pkg::alu_sub;
                id_next.imm       = id_b_imm;
            end
            default: id_next.valid = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    logic [cpu_pkg::xlen-1:0] ex_fwd_a;
    logic [cpu_pkg::xlen-1:0] ex_fwd_b;
    logic [cpu_pkg::xlen-1:0] ex_alu_b;
    logic [cpu_pkg::xlen-1:0] ex_result;

    assign ex_fwd_a = forward(idex.rs1, idex.rs1_data, exmem, memwb);
    assign ex_fwd_b = forward(idex.rs2, idex.rs2_data, exmem, memwb);
    assign ex_alu_b = (idex.alu_src == cpu_pkg::alu_src_imm) ? idex.imm : ex_fwd_b;

    alu u_alu (
        .op     (idex.alu_op),
        .a      (ex_fwd_a),
        .b      (ex_alu_b),
        .result (ex_result)
    );

    // ------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idex  <= '0;
            exmem <= '0;
            memwb <= '0;
        end else begin
            idex <= id_next;

            exmem.valid     <= idex.valid;
            exmem.reg_write <= idex.reg_write;
            exmem.branch_op <= idex.branch_op;
            exmem.zero      <= ex_result == '0;
            exmem.target    <= idex.pc + idex.imm;
            exmem.rd        <= idex.rd;
            exmem.result    <= ex_result;

            memwb.valid     <= exmem.valid;  // Branch itself moves on
            memwb.reg_write <= exmem.reg_write;
            memwb.rd        <= exmem.rd;
            memwb.result    <= exmem.result;

            if (branch_taken) begin
                idex.valid  <= 1'b0;
                exmem.valid <= 1'b0;
            end
        end
    end

    // Writeback announce
    assign retire.valid = memwb.valid && memwb.reg_write && memwb.rd != '0;
    assign retire.rd    = memwb.rd;
    assign retire.data  = memwb.result;

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------------------------------------
    // Widths and encodings
    // ------------------------------------------------------------
    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;

    localparam logic [6:0] opcode_op     = 7'b0110011;  // R-type
    localparam logic [6:0] opcode_op_imm = 7'b0010011;  // I-type ALU
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // Operand b source
    localparam logic alu_src_reg = 1'b0;
    localparam logic alu_src_imm = 1'b1;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        not_branch,
        beq
    } branch_op_e;

    // ------------------------------------------------------------
    // Ports and pipeline registers
    // ------------------------------------------------------------
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic                  alu_src;
        logic                  reg_write;
        branch_op_e            branch_op;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
    } idex_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        branch_op_e            branch_op;
        logic                  zero;      // rs1 - rs2 == 0
        logic [xlen-1:0]       target;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } exmem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } memwb_t;

endpackage

// File: src/cpu_subsystem.sv
`timescale 1ns/1ns

module cpu_subsystem #(
    parameter int unsigned imem_addr_w = 8
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     prog_we,
    input  logic [imem_addr_w-1:0]   prog_addr,
    input  logic [31:0]              prog_data,
    output cpu_pkg::retire_t         retire
);
    cpu_pkg::fetch_req_t      fetch_req;
    logic [cpu_pkg::xlen-1:0] fetch_data;

    // ------------------------------------------------------------
    // Core and instruction memory
    // ------------------------------------------------------------
    cpu u_cpu (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_req  (fetch_req),
        .fetch_data (fetch_data),
        .retire     (retire)
    );

    instr_mem #(
        .addr_w (imem_addr_w)
    ) u_instr_mem (
        .clk        (clk),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .fetch_req  (fetch_req),
        .fetch_data (fetch_data)
    );

endmodule

// File: src/instr_mem.sv
`timescale 1ns/1ns

module instr_mem #(
    parameter int unsigned addr_w = 8
) (
    input  logic                       clk,
    input  logic                       prog_we,
    input  logic [addr_w-1:0]          prog_addr,
    input  logic [31:0]                prog_data,
    input  cpu_pkg::fetch_req_t        fetch_req,
    output logic [31:0]                fetch_data
);
    logic [31:0] mem [0:2**addr_w-1];

    // Program load port, one word per strobe
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Registered read, word address from byte PC
    always_ff @(posedge clk) begin
        if (fetch_req.valid) begin
            fetch_data <= mem[fetch_req.addr[addr_w+1:2]];
        end
    end

endmodule

// File: src/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                           clk,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_reg1,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_reg2,
    input  logic                           write_enable,
    input  logic [cpu_pkg::reg_addr_w-1:0] write_reg,
    input  logic [cpu_pkg::xlen-1:0]       write_data,
    output logic [cpu_pkg::xlen-1:0]       read_data1,
    output logic [cpu_pkg::xlen-1:0]       read_data2
);
    // x0 has no storage
    logic [cpu_pkg::xlen-1:0] regs [1:2**cpu_pkg::reg_addr_w-1];

    always_ff @(posedge clk) begin
        if (write_enable && write_reg != '0) begin
            regs[write_reg] <= write_data;
        end
    end

    // Write-first: a same-cycle write is visible to decode
    always_comb begin
        if (read_reg1 == '0) read_data1 = '0;
        else if (write_enable && write_reg == read_reg1) read_data1 = write_data;
        else read_data1 = regs[read_reg1];

        if (read_reg2 == '0) read_data2 = '0;
        else if (write_enable && write_reg == read_reg2) read_data2 = write_data;
        else read_data2 = regs[read_reg2];
    end

endmodule

// File: test/cpu_checker.sv
`timescale 1ns/1ns

module cpu_checker (
    input logic                clk,
    input logic                reset_n,
    input cpu_pkg::fetch_req_t fetch_req,
    input cpu_pkg::retire_t    retire
);
    int unsigned fail_count = 0;  // Assertion failures so far

    a_retire_rd_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
        retire.valid |-> retire.rd != '0)
    else begin
        $error("Retire strobe with rd equal to x0");
        fail_count++;
    end

    // Nothing moves while reset is low
    a_quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> !retire.valid && !fetch_req.valid)
    else begin
        $error("Retire or fetch valid during reset");
        fail_count++;
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        fetch_req.valid |-> fetch_req.addr[1:0] == 2'b00)
    else begin
        $error("Fetch address 0x%08h not word aligned", fetch_req.addr);
        fail_count++;
    end

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
    localparam int unsigned imem_addr_w = 8;
    localparam int unsigned prog_len    = 60;
    localparam int unsigned wait_limit  = 100;
    localparam int unsigned tail_cycles = 50;

    logic                   clk;
    logic                   reset_n;
    logic                   load_done;
    logic                   prog_we;
    logic [imem_addr_w-1:0] prog_addr;
    logic [31:0]            prog_data;
    cpu_pkg::retire_t       retire;

    // Generated program, one entry per instruction
    logic [6:0]  p_opcode [prog_len];
    logic [2:0]  p_funct3 [prog_len];
    logic        p_alt    [prog_len];   // funct7 bit 5
    logic [4:0]  p_rd     [prog_len];
    logic [4:0]  p_rs1    [prog_len];
    logic [4:0]  p_rs2    [prog_len];
    logic [31:0] p_imm    [prog_len];   // Sign-extended I or B immediate

    cpu_pkg::retire_t expected [$];

    tb_clock_gen u_clock_gen (
        .load_done (load_done),
        .clk       (clk),
        .reset_n   (reset_n)
    );

    cpu_subsystem #(
        .imem_addr_w (imem_addr_w)
    ) DUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .retire    (retire)
    );

    bind cpu_subsystem cpu_checker u_checker (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_req (fetch_req),
        .retire    (retire)
    );

    // ------------------------------------------------------------
    // Program generation and instruction-set model
    // ------------------------------------------------------------
    task automatic make_program;
        logic [4:0]  recent [3];  // Last three destinations
        logic [11:0] imm12;
        int unsigned kind;
        recent[0] = '0;
        recent[1] = '0;
        recent[2] = '0;
        for (int unsigned i = 0; i < prog_len; i++) begin
            kind        = $urandom_range(0, 9);
            imm12       = 12'($urandom_range(0, 4095));
            p_rd[i]     = 5'($urandom_range(0, 7));
            p_rs1[i]    = 5'($urandom_range(0, 7));
            p_rs2[i]    = 5'($urandom_range(0, 7));
            p_funct3[i] = 3'($urandom_range(0, 7));
            p_alt[i]    = 1'b0;
            p_imm[i]    = {{20{imm12[11]}}, imm12};
            if ($urandom_range(0, 1) == 1) begin
                p_rs1[i] = recent[$urandom_range(0, 2)];  // Distance 1 to 3
            end
            if (i < 7) begin
                // Prologue gives x1..x7 known values
                p_opcode[i] = cpu_pkg::opcode_op_imm;
                p_funct3[i] = 3'd0;
                p_rd[i]     = 5'(i + 1);
                p_rs1[i]    = '0;
            end else if (kind < 2) begin
                p_opcode[i] = cpu_pkg::opcode_branch;
                p_funct3[i] = 3'd0;
                if (kind == 0) begin
                    p_rs2[i] = p_rs1[i];  // Always taken
                end
                p_imm[i] = $urandom_range(1, 5) << 2;
            end else if (kind < 6) begin
                p_opcode[i] = cpu_pkg::opcode_op;
                if (p_funct3[i] == 3'd0 || p_funct3[i] == 3'd5) begin
                    p_alt[i] = 1'($urandom_range(0, 1));
                end
            end else begin
                p_opcode[i] = cpu_pkg::opcode_op_imm;
                if (p_funct3[i] == 3'd3) begin
                    p_funct3[i] = 3'd2;  // SLTI instead of SLTIU
                end
                if (p_funct3[i] == 3'd1 || p_funct3[i] == 3'd5) begin
                    p_alt[i] = p_funct3[i] == 3'd5 && $urandom_range(0, 1) == 1;
                    p_imm[i] = {20'd0, 1'b0, p_alt[i], 5'd0, imm12[4:0]};
                end
            end
            if (p_opcode[i] != cpu_pkg::opcode_branch) begin
                recent[2] = recent[1];
                recent[1] = recent[0];
                recent[0] = p_rd[i];
            end
        end
    endtask

    function automatic logic [31:0] encode(int unsigned i);
        case (p_opcode[i])
            cpu_pkg::opcode_op: begin
                return {1'b0, p_alt[i], 5'd0, p_rs2[i], p_rs1[i], p_funct3[i],
                        p_rd[i], p_opcode[i]};
            end
            cpu_pkg::opcode_op_imm: begin
                return {p_imm[i][11:0], p_rs1[i], p_funct3[i], p_rd[i], p_opcode[i]};
            end
            default: begin
                return {p_imm[i][12], p_imm[i][10:5], p_rs2[i], p_rs1[i], 3'b000,
                        p_imm[i][4:1], p_imm[i][11], p_opcode[i]};
            end
        endcase
    endfunction

    // RV32I integer semantics by funct3
    function automatic logic [31:0] isa_result(logic [2:0] funct3, logic alt,
                                               logic [31:0] a, logic [31:0] b);
        case (funct3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];  // Sign fill
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model;
        logic [31:0]      regs [32];
        logic [31:0]      b;
        cpu_pkg::retire_t entry;
        int unsigned      pc;  // Instruction index
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc = 0;
        while (pc < prog_len) begin
            if (p_opcode[pc] == cpu_pkg::opcode_branch) begin
                if (regs[p_rs1[pc]] == regs[p_rs2[pc]]) begin
                    pc = pc + (p_imm[pc] >> 2);
                end else begin
                    pc = pc + 1;
                end
            end else begin
                b = (p_opcode[pc] == cpu_pkg::opcode_op) ? regs[p_rs2[pc]] : p_imm[pc];
                entry.valid = 1'b1;
                entry.rd    = p_rd[pc];
                entry.data  = isa_result(p_funct3[pc], p_alt[pc], regs[p_rs1[pc]], b);
                if (entry.rd != '0) begin  // x0 stays zero
                    regs[entry.rd] = entry.data;
                    expected.push_back(entry);
                end
                pc = pc + 1;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Driving and checking
    // ------------------------------------------------------------
    task automatic load_program;
        for (int unsigned a = 0; a < 2**imem_addr_w; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = imem_addr_w'(a);
            prog_data = (a < prog_len) ? encode(a) : {25'd0, cpu_pkg::opcode_branch};
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic wait_reset_release;
        int unsigned n;
        n = 0;
        while (reset_n !== 1'b1 && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (reset_n !== 1'b1) begin
            $display("Reset was not released after the program load");
            $display("Finished with errors");
            $fatal(1, "Reset timeout");
        end
    endtask

    task automatic wait_retire(output cpu_pkg::retire_t got);
        int unsigned n;
        n = 0;
        do begin
            @(negedge clk);  // Retire is stable mid-cycle
            n++;
        end while (!retire.valid && n < wait_limit);
        if (!retire.valid) begin
            $display("No retire arrived within %0d cycles", wait_limit);
            $display("Finished with errors");
            $fatal(1, "Retire timeout");
        end
        got = retire;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
            $display("Finished with errors");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_no_more_retires;
        for (int unsigned n = 0; n < tail_cycles; n++) begin
            @(negedge clk);
            if (retire.valid) begin
                $display("Unexpected retire of x%0d after the program ended", retire.rd);
                $display("Finished with errors");
                $fatal(1, "Extra retire");
            end
        end
    endtask

    initial begin
        cpu_pkg::retire_t got;
        cpu_pkg::retire_t want;
        void'($urandom(32'hc927));
        load_done = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;

        make_program();
        run_model();
        load_program();
        load_done = 1'b1;
        wait_reset_release();

        while (expected.size() > 0) begin
            want = expected.pop_front();
            wait_retire(got);
            check_value("retire.rd", 32'(got.rd), 32'(want.rd));
            check_value("retire.data", got.data, want.data);
        end
        check_no_more_retires();

        if (DUT.u_checker.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d assertion failures in the checker", DUT.u_checker.fail_count);
            $display("Finished with errors");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int unsigned half_period  = 2,
    parameter int unsigned reset_cycles = 3,
    parameter int unsigned load_limit   = 1000
) (
    input  logic load_done,
    output logic clk,
    output logic reset_n
);
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset covers the program load, then three more cycles
    initial begin
        reset_n = 1'b0;
        for (int unsigned n = 0; n < load_limit && load_done !== 1'b1; n++) begin
            @(posedge clk);
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;  // Released on a falling edge
    end

endmodule
